// File: common/sdmac_pkg.sv
/*
  SDMAC shared definitions
  Bus widths, register offsets, CNTR and ISTR bit positions,
  and the write-word union that decodes one Wishbone write word
  as either a control word or an ACR word.
*/
`default_nettype none

package sdmac_pkg;

  // Bus widths
  localparam int DATA_W = 32;  // Wishbone data and FIFO word
  localparam int ADR_W  = 8;   // Byte address

  // Register map, byte offsets
  localparam logic [ADR_W-1:0] OFS_CNTR    = 8'h00;  // Control, r/w
  localparam logic [ADR_W-1:0] OFS_ACR     = 8'h04;  // Address counter, r/w
  localparam logic [ADR_W-1:0] OFS_ISTR    = 8'h08;  // Interrupt status, r/o
  localparam logic [ADR_W-1:0] OFS_ST_DMA  = 8'h0C;  // Start DMA strobe
  localparam logic [ADR_W-1:0] OFS_SP_DMA  = 8'h10;  // Stop DMA strobe
  localparam logic [ADR_W-1:0] OFS_CLR_INT = 8'h14;  // Clear interrupt strobe
  localparam logic [ADR_W-1:0] OFS_FLUSH   = 8'h18;  // Flush FIFO strobe
  localparam logic [ADR_W-1:0] OFS_FIFO    = 8'h1C;  // Data register, read pops

  // Control register
  localparam int CNTR_W      = 9;
  localparam int CNTR_PRESET = 4;  // Peripheral reset
  localparam int CNTR_INTENA = 2;  // Interrupt enable
  localparam int CNTR_DMADIR = 1;  // 0 = device to memory
  localparam int CNTR_DMAENA = 8;  // Read only, set/clear by strobes

  // Interrupt status register
  localparam int ISTR_W        = 9;
  localparam int ISTR_FE       = 0;  // FIFO empty
  localparam int ISTR_FF       = 1;  // FIFO full
  localparam int ISTR_FULL_EVT = 2;  // Sticky, FIFO became full
  localparam int ISTR_INT_P    = 7;  // Pending = sticky event & intena

  // Write word seen as a control word
  typedef struct packed {
    logic [26:0] rsvd_hi;
    logic        preset;   // Bit 4
    logic        rsvd_3;
    logic        intena;   // Bit 2
    logic        dmadir;   // Bit 1
    logic        rsvd_0;
  } cntr_view_t;

  // Write word seen as an ACR word
  typedef struct packed {
    logic [29:0] waddr;  // Longword address
    logic        a1;     // Word select, exported
    logic        a0;
  } acr_view_t;

  // Same bus word, decoded by target register
  typedef union packed {
    cntr_view_t cntr;
    acr_view_t  acr;
  } sdmac_wdata_u;

endpackage

`default_nettype wire

// File: regs/sdmac_addr_decode.sv
/*
  SDMAC address decoder
  Turns the Wishbone byte address and direction into one-hot
  register selects and write strobes, all qualified by access,
  the cycle in which the register block acks.
*/
`timescale 1ns/1ps
`default_nettype none

module sdmac_addr_decode (
  input  wire logic [sdmac_pkg::ADR_W-1:0] adr,
  input  wire logic                        we,
  input  wire logic                        access,   // Ack-raising cycle
  output logic                             cntr_rd,
  output logic                             cntr_wr,
  output logic                             acr_rd,
  output logic                             acr_wr,
  output logic                             istr_rd,
  output logic                             fifo_rd,  // Pops head word
  output logic                             st_dma,
  output logic                             sp_dma,
  output logic                             clr_int,
  output logic                             flush
);

  logic rd;  // Qualified read
  logic wr;  // Qualified write

  assign rd = access & ~we;
  assign wr = access & we;

  // Readable registers
  assign cntr_rd = rd & (adr == sdmac_pkg::OFS_CNTR);
  assign acr_rd  = rd & (adr == sdmac_pkg::OFS_ACR);
  assign istr_rd = rd & (adr == sdmac_pkg::OFS_ISTR);
  assign fifo_rd = rd & (adr == sdmac_pkg::OFS_FIFO);

  // Writable registers
  assign cntr_wr = wr & (adr == sdmac_pkg::OFS_CNTR);
  assign acr_wr  = wr & (adr == sdmac_pkg::OFS_ACR);   // ISTR writes fall through

  // Action strobes, write data ignored
  assign st_dma  = wr & (adr == sdmac_pkg::OFS_ST_DMA);
  assign sp_dma  = wr & (adr == sdmac_pkg::OFS_SP_DMA);
  assign clr_int = wr & (adr == sdmac_pkg::OFS_CLR_INT);
  assign flush   = wr & (adr == sdmac_pkg::OFS_FLUSH);

endmodule

`default_nettype wire

// File: regs/sdmac_cntr.sv
/*
  SDMAC control register
  Holds peripheral reset, interrupt enable and DMA direction,
  plus the DMA enable flag that is set by the start strobe and
  cleared by the stop strobe.
*/
`timescale 1ns/1ps
`default_nettype none

module sdmac_cntr (
  input  wire logic                         CLK,
  input  wire logic                         RST_,
  input  wire logic                         cntr_wr,
  input  wire logic                         st_dma,     // Start DMA
  input  wire logic                         sp_dma,     // Stop DMA
  input  wire logic                         wr_preset,
  input  wire logic                         wr_intena,
  input  wire logic                         wr_dmadir,
  output logic      [sdmac_pkg::CNTR_W-1:0] cntr_o,     // Read view
  output logic                              intena,
  output logic                              preset,
  output logic                              dma_dir,
  output logic                              dma_ena
);

  // Writable control bits
  always_ff @(posedge CLK) begin
    if (!RST_) begin
      preset  <= 1'b0;
      intena  <= 1'b0;
      dma_dir <= 1'b0;
    end else if (cntr_wr) begin
      preset  <= wr_preset;
      intena  <= wr_intena;
      dma_dir <= wr_dmadir;
    end
  end

  // DMA enable flag
  always_ff @(posedge CLK) begin
    if (!RST_)
      dma_ena <= 1'b0;
    else if (sp_dma)  // Stop wins over start
      dma_ena <= 1'b0;
    else if (st_dma)
      dma_ena <= 1'b1;
  end

  always_comb begin
    cntr_o                         = '0;  // Unused bits read zero
    cntr_o[sdmac_pkg::CNTR_PRESET] = preset;
    cntr_o[sdmac_pkg::CNTR_INTENA] = intena;
    cntr_o[sdmac_pkg::CNTR_DMADIR] = dma_dir;
    cntr_o[sdmac_pkg::CNTR_DMAENA] = dma_ena;
  end

endmodule

`default_nettype wire

// File: regs/sdmac_istr.sv
/*
  SDMAC interrupt status register
  Reports FIFO empty and full, latches a sticky event when the
  FIFO fills, and forms the pending bit from the event and the
  interrupt enable. Drives the active-low interrupt from a flop.
*/
`timescale 1ns/1ps
`default_nettype none

module sdmac_istr (
  input  wire logic                         CLK,
  input  wire logic                         RST_,
  input  wire logic                         fifo_empty,
  input  wire logic                         fifo_full,
  input  wire logic                         clr_int,  // Write strobe
  input  wire logic                         intena,
  output logic      [sdmac_pkg::ISTR_W-1:0] istr_o,
  output logic                              int_o_    // Active low
);

  logic full_evt;  // Sticky FIFO-full event
  logic int_p;     // Interrupt pending

  // Clear takes this edge; a still-full FIFO sets it again next edge
  always_ff @(posedge CLK) begin
    if (!RST_)
      full_evt <= 1'b0;
    else if (clr_int)
      full_evt <= 1'b0;
    else if (fifo_full)
      full_evt <= 1'b1;
  end

  assign int_p = full_evt & intena;

  // One cycle behind pending
  always_ff @(posedge CLK) begin
    if (!RST_)
      int_o_ <= 1'b1;
    else
      int_o_ <= ~int_p;
  end

  always_comb begin
    istr_o                           = '0;
    istr_o[sdmac_pkg::ISTR_FE]       = fifo_empty;
    istr_o[sdmac_pkg::ISTR_FF]       = fifo_full;
    istr_o[sdmac_pkg::ISTR_FULL_EVT] = full_evt;
    istr_o[sdmac_pkg::ISTR_INT_P]    = int_p;
  end

endmodule

`default_nettype wire

// File: regs/sdmac_regs.sv
/*
  SDMAC register block
  Wishbone classic slave with a registered one-cycle ack.
  Decodes accesses into register reads, writes and strobes,
  holds the ACR, multiplexes read data and issues the FIFO
  pop and flush pulses.
*/
`timescale 1ns/1ps
`default_nettype none

module sdmac_regs (
  input  wire logic                         CLK,
  input  wire logic                         RST_,
  input  wire logic                         wb_cyc,
  input  wire logic                         wb_stb,
  input  wire logic                         wb_we,
  input  wire logic [sdmac_pkg::ADR_W-1:0]  wb_adr,
  input  wire logic [sdmac_pkg::DATA_W-1:0] wb_dat_w,
  input  wire logic [sdmac_pkg::DATA_W-1:0] fifo_rdata,  // Head word
  input  wire logic                         fifo_empty,
  input  wire logic                         fifo_full,
  output logic      [sdmac_pkg::DATA_W-1:0] wb_dat_r,
  output logic                              wb_ack,
  output logic                              int_o_,
  output logic                              preset,
  output logic                              a1,          // ACR bit 1
  output logic                              dma_ena,
  output logic                              dma_dir,
  output logic                              fill_ena,    // DMA on, dev to mem
  output logic                              fifo_pop,
  output logic                              fifo_flush
);

  logic                              access;  // Request seen, ack next edge
  logic                              cntr_rd, cntr_wr, acr_rd, acr_wr;
  logic                              istr_rd, fifo_rd;
  logic                              st_dma, sp_dma, clr_int, flush;
  logic                              intena;
  logic [sdmac_pkg::CNTR_W-1:0]      cntr_o;
  logic [sdmac_pkg::ISTR_W-1:0]      istr_o;
  logic [sdmac_pkg::DATA_W-1:0]      acr_q;
  logic [sdmac_pkg::DATA_W-1:0]      rd_mux;
  sdmac_pkg::sdmac_wdata_u           wdat_u;  // Write word, two views

  assign access = wb_cyc & wb_stb & ~wb_ack;  // Ack low between accesses
  assign wdat_u = wb_dat_w;

  sdmac_addr_decode u_addr_decode (
    .adr     (wb_adr),
    .we      (wb_we),
    .access  (access),
    .cntr_rd (cntr_rd),
    .cntr_wr (cntr_wr),
    .acr_rd  (acr_rd),
    .acr_wr  (acr_wr),
    .istr_rd (istr_rd),
    .fifo_rd (fifo_rd),
    .st_dma  (st_dma),
    .sp_dma  (sp_dma),
    .clr_int (clr_int),
    .flush   (flush)
  );

  sdmac_cntr u_cntr (
    .CLK       (CLK),
    .RST_      (RST_),
    .cntr_wr   (cntr_wr),
    .st_dma    (st_dma),
    .sp_dma    (sp_dma),
    .wr_preset (wdat_u.cntr.preset),
    .wr_intena (wdat_u.cntr.intena),
    .wr_dmadir (wdat_u.cntr.dmadir),
    .cntr_o    (cntr_o),
    .intena    (intena),
    .preset    (preset),
    .dma_dir   (dma_dir),
    .dma_ena   (dma_ena)
  );

  sdmac_istr u_istr (
    .CLK        (CLK),
    .RST_       (RST_),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .clr_int    (clr_int),
    .intena     (intena),
    .istr_o     (istr_o),
    .int_o_     (int_o_)
  );

  // Ack, pop and flush all line up on the same edge
  always_ff @(posedge CLK) begin
    if (!RST_) begin
      wb_ack     <= 1'b0;
      fifo_pop   <= 1'b0;
      fifo_flush <= 1'b0;
    end else begin
      wb_ack     <= access;
      fifo_pop   <= fifo_rd;  // FIFO advances at end of ack cycle
      fifo_flush <= flush;
    end
  end

  // Address counter, whole word kept
  always_ff @(posedge CLK) begin
    if (!RST_)
      acr_q <= '0;
    else if (acr_wr)
      acr_q <= {wdat_u.acr.waddr, wdat_u.acr.a1, wdat_u.acr.a0};
  end

  assign a1 = acr_q[1];

  // Read select, unmapped reads give zero
  always_comb begin
    rd_mux = '0;
    if (cntr_rd)
      rd_mux = {{(sdmac_pkg::DATA_W-sdmac_pkg::CNTR_W){1'b0}}, cntr_o};
    else if (acr_rd)
      rd_mux = acr_q;
    else if (istr_rd)
      rd_mux = {{(sdmac_pkg::DATA_W-sdmac_pkg::ISTR_W){1'b0}}, istr_o};
    else if (fifo_rd)
      rd_mux = fifo_rdata;
  end

  // Captured from pre-edge state, valid while ack high
  always_ff @(posedge CLK) begin
    if (access)
      wb_dat_r <= rd_mux;
  end

  assign fill_ena = dma_ena & ~dma_dir;

endmodule

`default_nettype wire

// File: design/sdmac_fifo.sv
/*
  SDMAC data FIFO
  Circular buffer between the peripheral write port and the CPU
  data register. Pointers carry one extra wrap bit. Head word is
  presented combinationally, and flush clears both pointers.
*/
`timescale 1ns/1ps
`default_nettype none

module sdmac_fifo #(
  parameter int FIFO_DEPTH = 4  // Power of two
) (
  input  wire logic                         CLK,
  input  wire logic                         RST_,
  input  wire logic                         fill_ena,   // DMA on, dev to mem
  input  wire logic                         dev_wr,
  input  wire logic [sdmac_pkg::DATA_W-1:0] dev_data,
  input  wire logic                         pop,
  input  wire logic                         flush,
  output logic                              dev_ready,
  output logic      [sdmac_pkg::DATA_W-1:0] rdata,      // Zero when empty
  output logic                              empty,
  output logic                              full
);

  localparam int AW = $clog2(FIFO_DEPTH);

  logic [sdmac_pkg::DATA_W-1:0] mem [FIFO_DEPTH];
  logic [AW:0]                  wr_ptr;  // MSB is wrap bit
  logic [AW:0]                  rd_ptr;
  logic                         push;

  assign empty     = (wr_ptr == rd_ptr);
  assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign dev_ready = fill_ena & ~full;
  assign push      = dev_wr & dev_ready;

  // Pointers, flush beats a same-cycle push
  always_ff @(posedge CLK) begin
    if (!RST_) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty)  // Pop of empty FIFO ignored
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Storage
  always_ff @(posedge CLK) begin
    if (push && !flush)
      mem[wr_ptr[AW-1:0]] <= dev_data;
  end

  assign rdata = empty ? '0 : mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

// File: design/sdmac_top.sv
/*
  SDMAC register subsystem top
  Register block behind a Wishbone classic slave, joined to the
  data FIFO that the peripheral fills and the CPU drains.
*/
`timescale 1ns/1ps
`default_nettype none

module sdmac_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic                         CLK,
  input  wire logic                         RST_,
  input  wire logic                         wb_cyc,
  input  wire logic                         wb_stb,
  input  wire logic                         wb_we,
  input  wire logic [sdmac_pkg::ADR_W-1:0]  wb_adr,
  input  wire logic [sdmac_pkg::DATA_W-1:0] wb_dat_w,
  output logic      [sdmac_pkg::DATA_W-1:0] wb_dat_r,
  output logic                              wb_ack,
  input  wire logic                         dev_wr,     // Peripheral push
  input  wire logic [sdmac_pkg::DATA_W-1:0] dev_data,
  output logic                              dev_ready,
  output logic                              int_o_,     // Active low
  output logic                              preset,
  output logic                              a1,
  output logic                              dma_ena,
  output logic                              dma_dir
);

  logic                         fill_ena;
  logic                         fifo_pop;
  logic                         fifo_flush;
  logic                         fifo_empty;
  logic                         fifo_full;
  logic [sdmac_pkg::DATA_W-1:0] fifo_rdata;

  sdmac_regs u_regs (
    .CLK        (CLK),
    .RST_       (RST_),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .fifo_rdata (fifo_rdata),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .int_o_     (int_o_),
    .preset     (preset),
    .a1         (a1),
    .dma_ena    (dma_ena),
    .dma_dir    (dma_dir),
    .fill_ena   (fill_ena),
    .fifo_pop   (fifo_pop),
    .fifo_flush (fifo_flush)
  );

  sdmac_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .CLK       (CLK),
    .RST_      (RST_),
    .fill_ena  (fill_ena),
    .dev_wr    (dev_wr),
    .dev_data  (dev_data),
    .pop       (fifo_pop),
    .flush     (fifo_flush),
    .dev_ready (dev_ready),
    .rdata     (fifo_rdata),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

endmodule

`default_nettype wire

// File: verif/sdmac_sva.sv
/*
  SDMAC register block assertions
  Bound to the register block. Covers the Wishbone ack pulse,
  ack qualification by the request, and the interrupt output
  while interrupts are disabled.
*/
`timescale 1ns/1ps
`default_nettype none

module sdmac_sva (
  input wire logic CLK,
  input wire logic RST_,
  input wire logic wb_cyc,
  input wire logic wb_stb,
  input wire logic wb_ack,
  input wire logic int_o_,
  input wire logic intena
);

  int fail_count = 0;  // Failed assertion count, read at end of run

  // One-cycle ack, never stretched
  a_ack_pulse: assert property (@(posedge CLK) disable iff (!RST_) wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack high for two consecutive cycles");
      fail_count++;
    end

  // Ack only after a request with ack low
  a_ack_req: assert property (@(posedge CLK) disable iff (!RST_)
    wb_ack |-> $past(wb_cyc & wb_stb & ~wb_ack))
    else begin
      $error("wb_ack raised without a preceding cyc and stb");
      fail_count++;
    end

  // Interrupt output lags pending by one flop
  a_int_off: assert property (@(posedge CLK) disable iff (!RST_)
    (!intena && !$past(intena)) |-> int_o_)
    else begin
      $error("int_o_ low while interrupts are disabled");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: verif/sdmac_checker.sv
/*
  SDMAC reference model and checker
  Watches the Wishbone bus and the peripheral port, mirrors the
  control bits, ACR, DMA enable, FIFO contents and sticky event,
  predicts read data and the register outputs, and compares.
  Prints one line per finished test.
*/
`timescale 1ns/1ps
`default_nettype none

module sdmac_checker #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic                         CLK,
  input  wire logic                         RST_,
  input  wire logic                         wb_cyc,
  input  wire logic                         wb_stb,
  input  wire logic                         wb_we,
  input  wire logic [sdmac_pkg::ADR_W-1:0]  wb_adr,
  input  wire logic [sdmac_pkg::DATA_W-1:0] wb_dat_w,
  input  wire logic [sdmac_pkg::DATA_W-1:0] wb_dat_r,
  input  wire logic                         wb_ack,
  input  wire logic                         dev_wr,
  input  wire logic [sdmac_pkg::DATA_W-1:0] dev_data,
  input  wire logic                         dev_ready,
  input  wire logic                         int_o_,
  input  wire logic                         preset,
  input  wire logic                         a1,
  input  wire logic                         dma_ena,
  input  wire logic                         dma_dir,
  input  wire logic                         test_end,  // Pulse from driver
  input  wire logic [7:0]                   test_id,
  output int                                checks,
  output int                                errors,
  output int                                tests_failed
);

  logic [31:0] q [$];  // Model FIFO with head at index 0
  logic        m_preset;
  logic        m_intena;
  logic        m_dmadir;
  logic        m_dmaena;
  logic        m_evt;    // Sticky full event
  logic        m_int_n;  // Expected int_o_
  logic        m_ack;    // Expected wb_ack
  logic [31:0] m_acr;
  logic        pop_pend;  // Pop lands one edge after the ack edge
  logic        flush_pend;
  logic        rd_pend;
  logic [31:0] rd_exp;
  logic        m_full;
  logic        m_empty;
  logic        m_ready;
  logic        access;
  logic        push;
  logic        int_next;
  int          test_errs;

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Read word from the model state before the access edge
  function automatic logic [31:0] predict_read(input logic [7:0] adr);
    logic [31:0] v;
    v = '0;
    case (adr)
      sdmac_pkg::OFS_CNTR: begin
        v[sdmac_pkg::CNTR_PRESET] = m_preset;
        v[sdmac_pkg::CNTR_INTENA] = m_intena;
        v[sdmac_pkg::CNTR_DMADIR] = m_dmadir;
        v[sdmac_pkg::CNTR_DMAENA] = m_dmaena;
      end
      sdmac_pkg::OFS_ACR: v = m_acr;
      sdmac_pkg::OFS_ISTR: begin
        v[sdmac_pkg::ISTR_FE]       = m_empty;
        v[sdmac_pkg::ISTR_FF]       = m_full;
        v[sdmac_pkg::ISTR_FULL_EVT] = m_evt;
        v[sdmac_pkg::ISTR_INT_P]    = m_evt & m_intena;
      end
      sdmac_pkg::OFS_FIFO: v = (q.size() != 0) ? q[0] : 32'h0;  // Empty reads zero
      default: v = '0;  // Unmapped and strobe addresses
    endcase
    return v;
  endfunction

  always @(posedge CLK) begin
    if (!RST_) begin
      q.delete();
      m_preset   = 1'b0;
      m_intena   = 1'b0;
      m_dmadir   = 1'b0;
      m_dmaena   = 1'b0;
      m_evt      = 1'b0;
      m_int_n    = 1'b1;
      m_ack      = 1'b0;
      m_acr      = '0;
      pop_pend   = 1'b0;
      flush_pend = 1'b0;
      rd_pend    = 1'b0;
      test_errs  = 0;
    end else begin
      m_full  = (q.size() == FIFO_DEPTH);
      m_empty = (q.size() == 0);
      m_ready = m_dmaena & ~m_dmadir & ~m_full;  // Fill enabled and room left
      check_bit("dev_ready", dev_ready, m_ready);
      check_bit("int_o_", int_o_, m_int_n);
      check_bit("dma_ena", dma_ena, m_dmaena);
      check_bit("dma_dir", dma_dir, m_dmadir);
      check_bit("preset", preset, m_preset);
      check_bit("a1", a1, m_acr[1]);
      check_bit("wb_ack", wb_ack, m_ack);
      if (m_ack && rd_pend) begin
        check_value("wb_dat_r", wb_dat_r, rd_exp);
        rd_pend = 1'b0;
      end
      access = wb_cyc & wb_stb & ~m_ack;
      if (access && !wb_we) begin
        rd_exp  = predict_read(wb_adr);
        rd_pend = 1'b1;
      end
      push     = dev_wr & m_ready;
      int_next = ~(m_evt & m_intena);
      if (access && wb_we && (wb_adr == sdmac_pkg::OFS_CLR_INT))
        m_evt = 1'b0;
      else if (m_full)
        m_evt = 1'b1;  // Sets again while still full
      if (flush_pend) begin
        q.delete();  // Same-edge push lost
      end else begin
        if (pop_pend && (q.size() != 0))
          void'(q.pop_front());
        if (push)
          q.push_back(dev_data);
      end
      pop_pend   = access & ~wb_we & (wb_adr == sdmac_pkg::OFS_FIFO);
      flush_pend = access & wb_we & (wb_adr == sdmac_pkg::OFS_FLUSH);
      m_int_n    = int_next;
      m_ack      = access;
      if (access && wb_we) begin
        case (wb_adr)
          sdmac_pkg::OFS_CNTR: begin
            m_preset = wb_dat_w[sdmac_pkg::CNTR_PRESET];
            m_intena = wb_dat_w[sdmac_pkg::CNTR_INTENA];
            m_dmadir = wb_dat_w[sdmac_pkg::CNTR_DMADIR];
          end
          sdmac_pkg::OFS_ACR:    m_acr = wb_dat_w;
          sdmac_pkg::OFS_ST_DMA: m_dmaena = 1'b1;
          sdmac_pkg::OFS_SP_DMA: m_dmaena = 1'b0;
          default: ;
        endcase
      end
      if (test_end) begin
        if (test_errs == 0) begin
          $display("Test %0d: pass", test_id);
        end else begin
          $display("Test %0d: FAIL with %0d mismatches", test_id, test_errs);
          tests_failed++;
        end
        test_errs = 0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/sdmac_tb.sv
/*
  SDMAC register subsystem testbench
  Runs an operation table of Wishbone reads, writes and
  peripheral pushes against the DUT, with LFSR push data.
  The checker model does the comparing. Ends with a summary
  line and the verdict, or on a cycle-count timeout.
*/
`timescale 1ns/1ps
`default_nettype none

module sdmac_tb;

  localparam int FIFO_DEPTH = 4;
  localparam int MAX_OPS    = 64;
  localparam int PUSH_WAIT  = 8;  // Cycles before a refused push is dropped
  localparam logic [1:0] K_RD   = 2'd0;
  localparam logic [1:0] K_WR   = 2'd1;
  localparam logic [1:0] K_PUSH = 2'd2;

  typedef struct packed {
    logic [1:0]                  kind;
    logic [sdmac_pkg::ADR_W-1:0] adr;
    logic [31:0]                 data;  // Zero in a push row takes LFSR word
    logic [7:0]                  test;
  } op_t;

  op_t         ops [MAX_OPS];
  int          n_ops = 0;
  int          n_tests = 0;
  int          limit = 0;   // Timeout limit set once table is loaded
  int          cycles = 0;
  int          idx;
  int          sva_errs;
  logic [31:0] lfsr;
  logic [31:0] word;

  logic                         CLK;
  logic                         RST_;
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic [sdmac_pkg::ADR_W-1:0]  wb_adr;
  logic [sdmac_pkg::DATA_W-1:0] wb_dat_w;
  logic [sdmac_pkg::DATA_W-1:0] wb_dat_r;
  logic                         wb_ack;
  logic                         dev_wr;
  logic [sdmac_pkg::DATA_W-1:0] dev_data;
  logic                         dev_ready;
  logic                         int_o_;
  logic                         preset;
  logic                         a1;
  logic                         dma_ena;
  logic                         dma_dir;
  logic                         test_end;
  logic [7:0]                   test_id;
  int                           checks;
  int                           errors;
  int                           tests_failed;

  sdmac_top #(.FIFO_DEPTH(FIFO_DEPTH)) sdmac_top_inst (
    .CLK(CLK), .RST_(RST_),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .dev_wr(dev_wr), .dev_data(dev_data), .dev_ready(dev_ready),
    .int_o_(int_o_), .preset(preset), .a1(a1), .dma_ena(dma_ena), .dma_dir(dma_dir)
  );

  sdmac_checker #(.FIFO_DEPTH(FIFO_DEPTH)) u_checker (
    .CLK(CLK), .RST_(RST_),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .dev_wr(dev_wr), .dev_data(dev_data), .dev_ready(dev_ready),
    .int_o_(int_o_), .preset(preset), .a1(a1), .dma_ena(dma_ena), .dma_dir(dma_dir),
    .test_end(test_end), .test_id(test_id),
    .checks(checks), .errors(errors), .tests_failed(tests_failed)
  );

  bind sdmac_regs sdmac_sva sva_inst (
    .CLK(CLK), .RST_(RST_), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_ack(wb_ack), .int_o_(int_o_), .intena(intena)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;  // 20 ns period
  end

  // Galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic next_lfsr_word(output logic [31:0] w);
    int i;
    w = '0;
    for (i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);  // One step per bit
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic add_op(input logic [1:0] kind, input logic [7:0] adr,
                        input logic [31:0] data, input int test);
    ops[n_ops].kind = kind;
    ops[n_ops].adr  = adr;
    ops[n_ops].data = data;
    ops[n_ops].test = 8'(test);
    n_ops++;
  endtask

  task automatic load_table;
    add_op(K_RD, sdmac_pkg::OFS_CNTR, 32'h0, 1);  // Reset values
    add_op(K_RD, sdmac_pkg::OFS_ACR, 32'h0, 1);
    add_op(K_RD, sdmac_pkg::OFS_ISTR, 32'h0, 1);
    add_op(K_RD, 8'h40, 32'h0, 1);                // Unmapped
    add_op(K_WR, sdmac_pkg::OFS_CNTR, 32'hFFFF_FFFF, 2);  // Writable bits only
    add_op(K_RD, sdmac_pkg::OFS_CNTR, 32'h0, 2);
    add_op(K_WR, sdmac_pkg::OFS_ACR, 32'hDEAD_BEEE, 2);   // a1 set
    add_op(K_RD, sdmac_pkg::OFS_ACR, 32'h0, 2);
    add_op(K_WR, sdmac_pkg::OFS_ACR, 32'h1234_5679, 2);   // a1 clear
    add_op(K_RD, sdmac_pkg::OFS_ACR, 32'h0, 2);
    add_op(K_WR, sdmac_pkg::OFS_CNTR, 32'h0, 2);
    add_op(K_WR, sdmac_pkg::OFS_ST_DMA, 32'h0, 3);
    add_op(K_RD, sdmac_pkg::OFS_CNTR, 32'h0, 3);
    add_op(K_WR, sdmac_pkg::OFS_SP_DMA, 32'h0, 3);
    add_op(K_RD, sdmac_pkg::OFS_CNTR, 32'h0, 3);
    add_op(K_PUSH, 8'h00, 32'hA5A5_0001, 3);          // Refused with DMA off
    add_op(K_WR, sdmac_pkg::OFS_CNTR, 32'h0000_0002, 3);  // Mem to dev
    add_op(K_WR, sdmac_pkg::OFS_ST_DMA, 32'h0, 3);
    add_op(K_PUSH, 8'h00, 32'h0, 3);                  // Refused for wrong direction
    add_op(K_WR, sdmac_pkg::OFS_SP_DMA, 32'h0, 3);
    add_op(K_WR, sdmac_pkg::OFS_CNTR, 32'h0, 3);
    add_op(K_WR, sdmac_pkg::OFS_ST_DMA, 32'h0, 4);
    add_op(K_PUSH, 8'h00, 32'h0, 4);
    add_op(K_PUSH, 8'h00, 32'h0, 4);
    add_op(K_PUSH, 8'h00, 32'h0, 4);
    add_op(K_RD, sdmac_pkg::OFS_ISTR, 32'h0, 4);      // Neither empty nor full
    add_op(K_RD, sdmac_pkg::OFS_FIFO, 32'h0, 4);
    add_op(K_RD, sdmac_pkg::OFS_FIFO, 32'h0, 4);
    add_op(K_RD, sdmac_pkg::OFS_FIFO, 32'h0, 4);
    add_op(K_RD, sdmac_pkg::OFS_FIFO, 32'h0, 4);      // Empty FIFO reads zero
    add_op(K_RD, sdmac_pkg::OFS_ISTR, 32'h0, 4);
    add_op(K_WR, sdmac_pkg::OFS_CNTR, 32'h0000_0004, 5);  // Interrupts on with DMA running
    add_op(K_PUSH, 8'h00, 32'h0, 5);
    add_op(K_PUSH, 8'h00, 32'h0, 5);
    add_op(K_PUSH, 8'h00, 32'h0, 5);
    add_op(K_PUSH, 8'h00, 32'h0, 5);
    add_op(K_RD, sdmac_pkg::OFS_ISTR, 32'h0, 5);      // Full, event latches on this edge
    add_op(K_RD, sdmac_pkg::OFS_ISTR, 32'h0, 5);      // Full, sticky, pending
    add_op(K_WR, sdmac_pkg::OFS_FLUSH, 32'h0, 5);
    add_op(K_RD, sdmac_pkg::OFS_ISTR, 32'h0, 5);      // Empty with sticky kept
    add_op(K_RD, sdmac_pkg::OFS_FIFO, 32'h0, 5);
    add_op(K_WR, sdmac_pkg::OFS_CLR_INT, 32'h0, 5);
    add_op(K_RD, sdmac_pkg::OFS_ISTR, 32'h0, 5);
    add_op(K_WR, sdmac_pkg::OFS_SP_DMA, 32'h0, 5);
  endtask

  // Holds the request until ack seen
  task automatic wb_xfer(input logic we, input logic [7:0] adr, input logic [31:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = data;
    do begin
      @(posedge CLK);
      #2;
    end while (!wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic dev_push(input logic [31:0] data);
    int waited;
    waited   = 0;
    dev_wr   = 1'b1;
    dev_data = data;
    while (!dev_ready && waited < PUSH_WAIT) begin
      @(posedge CLK);
      #2;
      waited++;
    end
    if (dev_ready) begin  // Taken on the next edge
      @(posedge CLK);
      #2;
    end
    dev_wr = 1'b0;
  endtask

  // Read compare and int_o_ settle within two edges
  task automatic end_test(input logic [7:0] id);
    repeat (2) begin
      @(posedge CLK);
      #2;
    end
    test_id  = id;
    test_end = 1'b1;
    @(posedge CLK);
    #2;
    test_end = 1'b0;
    n_tests++;
  endtask

  always @(posedge CLK) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout: operation table not finished within %0d cycles", limit);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    RST_     = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    dev_wr   = 1'b0;
    dev_data = '0;
    test_end = 1'b0;
    test_id  = '0;
    lfsr     = 32'h5599_6ae4;
    load_table();
    limit = 4 * n_ops * 8;
    repeat (3) @(posedge CLK);
    #2 RST_ = 1'b1;
    for (idx = 0; idx < n_ops; idx++) begin
      case (ops[idx].kind)
        K_RD: wb_xfer(1'b0, ops[idx].adr, 32'h0);
        K_WR: wb_xfer(1'b1, ops[idx].adr, ops[idx].data);
        default: begin
          if (ops[idx].data == 32'h0)
            next_lfsr_word(word);
          else
            word = ops[idx].data;
          dev_push(word);
        end
      endcase
      if (idx == n_ops - 1 || ops[idx + 1].test != ops[idx].test)
        end_test(ops[idx].test);
    end
    sva_errs = sdmac_top_inst.u_regs.sva_inst.fail_count;
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion errors",
             n_tests, tests_failed, checks, errors, sva_errs);
    if (errors == 0 && tests_failed == 0 && sva_errs == 0 && checks > 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
common/sdmac_pkg.sv
regs/sdmac_addr_decode.sv
regs/sdmac_cntr.sv
regs/sdmac_istr.sv
regs/sdmac_regs.sv
design/sdmac_fifo.sv
design/sdmac_top.sv
verif/sdmac_sva.sv
verif/sdmac_checker.sv
verif/sdmac_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = sdmac_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))
PASS_MSG = Simulation completed successfully

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
